/* logic/ooo_pkg.sv */
package ooo_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // Major opcodes of the supported formats
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // Immediate forms share the register-form codes
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_op_e;

    typedef union packed {
        struct packed {
            logic [6:0]        funct7;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } r_fmt;
        struct packed {
            logic [11:0]       imm12;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } i_fmt;
    } inst_u;

endpackage

/* logic/core_if.sv */
interface dispatch_if import ooo_pkg::*; #(
    parameter int TAG_W = 3
);
    logic             we;
    alu_op_e          op;
    logic [XLEN-1:0]  vj;
    logic [TAG_W-1:0] qj;
    logic             qj_valid;
    logic [XLEN-1:0]  vk;
    logic [TAG_W-1:0] qk;
    logic             qk_valid;
    logic [TAG_W-1:0] dest;
    logic             full;

    modport source (output we, op, vj, qj, qj_valid, vk, qk, qk_valid, dest, input full);
    modport sink   (input we, op, vj, qj, qj_valid, vk, qk, qk_valid, dest, output full);
endinterface

interface cdb_if import ooo_pkg::*; #(
    parameter int TAG_W = 3
);
    logic             valid;
    logic [TAG_W-1:0] rob_id;
    logic [XLEN-1:0]  value;

    modport driver   (output valid, rob_id, value);
    modport listener (input valid, rob_id, value);
endinterface

interface rob_query_if import ooo_pkg::*; #(
    parameter int TAG_W = 3
);
    logic [TAG_W-1:0] id1;
    logic             ready1;
    logic [XLEN-1:0]  value1;
    logic [TAG_W-1:0] id2;
    logic             ready2;
    logic [XLEN-1:0]  value2;

    modport requester (output id1, id2, input ready1, value1, ready2, value2);
    modport responder (input id1, id2, output ready1, value1, ready2, value2);
endinterface

interface commit_if import ooo_pkg::*; #(
    parameter int TAG_W = 3
);
    logic              valid;
    logic [TAG_W-1:0]  id;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   value;

    modport source   (output valid, id, rd, value);
    modport receiver (input valid, id, rd, value);
endinterface

/* logic/fetch_queue.sv */
module fetch_queue import ooo_pkg::*; #(
    parameter int FQ_DEPTH = 4
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic [XLEN-1:0] inst_i,
    output logic [XLEN-1:0] inst_addr_o,
    output logic            inst_ce_o,
    input  logic            fq_pop_i,
    output logic            fq_valid_o,
    output logic [XLEN-1:0] fq_inst_o,
    output logic [XLEN-1:0] fq_pc_o
);

    localparam int PTR_W = $clog2(FQ_DEPTH);
    localparam int CNT_W = $clog2(FQ_DEPTH + 1);

    logic [XLEN-1:0]  inst_mem [FQ_DEPTH];
    logic [XLEN-1:0]  pc_mem   [FQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [XLEN-1:0]  pc_q;
    logic [XLEN-1:0]  flight_pc_q;
    logic             flight_q;
    logic             run_q;
    logic             pop;

    // Word in flight already owns a slot
    assign inst_ce_o   = run_q && (int'(count_q) + int'(flight_q) < FQ_DEPTH);
    assign inst_addr_o = pc_q;
    assign pop         = fq_pop_i && fq_valid_o;
    assign fq_valid_o  = (count_q != '0);
    assign fq_inst_o   = inst_mem[rd_ptr_q];
    assign fq_pc_o     = pc_mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_q    <= 1'b0;
            pc_q     <= '0;
            flight_q <= 1'b0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            run_q    <= 1'b1;
            flight_q <= inst_ce_o;
            if (inst_ce_o) begin
                pc_q <= pc_q + 32'd4;
            end
            if (flight_q) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(flight_q) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (inst_ce_o) begin
            flight_pc_q <= pc_q;
        end
        if (flight_q) begin
            inst_mem[wr_ptr_q] <= inst_i;
            pc_mem[wr_ptr_q]   <= flight_pc_q;
        end
    end

endmodule

/* logic/rename_issue.sv */
module rename_issue import ooo_pkg::*; #(
    parameter int  ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              fq_valid_i,
    input  logic [XLEN-1:0]   fq_inst_i,
    input  logic [XLEN-1:0]   fq_pc_i,
    output logic              fq_pop_o,
    input  logic              rob_full_i,
    input  logic [TAG_W-1:0]  rob_alloc_id_i,
    output logic              rob_alloc_we_o,
    output logic [REG_AW-1:0] rob_alloc_rd_o,
    output logic [XLEN-1:0]   rob_alloc_pc_o,
    rob_query_if.requester    query,
    commit_if.receiver        commit,
    dispatch_if.source        disp
);

    localparam int NREGS = 1 << REG_AW;

    inst_u             inst;
    logic              is_op;
    logic              is_imm;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   imm;
    logic              issue;
    logic              rf_we;
    logic [XLEN-1:0]   regs      [NREGS];
    logic [TAG_W-1:0]  rat_tag_q [NREGS];
    logic [NREGS-1:0]  rat_busy_q;

    assign inst   = fq_inst_i;
    assign is_op  = (inst.r_fmt.opcode == OPC_OP);
    assign is_imm = (inst.i_fmt.opcode == OPC_OP_IMM);
    assign rs1    = inst.r_fmt.rs1;
    assign rs2    = inst.r_fmt.rs2;
    // Unknown words go through as no-ops
    assign rd     = (is_op || is_imm) ? inst.r_fmt.rd : '0;
    assign imm    = {{(XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
    assign rf_we  = commit.valid && (commit.rd != '0);

    always_comb begin
        case (inst.r_fmt.funct3)
            3'b000:  disp.op = (is_op && inst.r_fmt.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  disp.op = ALU_SLL;
            3'b010:  disp.op = ALU_SLT;
            3'b100:  disp.op = ALU_XOR;
            3'b101:  disp.op = ALU_SRL;
            3'b110:  disp.op = ALU_OR;
            3'b111:  disp.op = ALU_AND;
            default: disp.op = ALU_ADD;
        endcase
    end

    // Register file read with bypass of the retiring result
    function automatic logic [XLEN-1:0] rf_read(input logic [REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (rf_we && commit.rd == addr) begin
            return commit.value;
        end
        return regs[addr];
    endfunction

    assign query.id1 = rat_tag_q[rs1];
    assign query.id2 = rat_tag_q[rs2];

    always_comb begin
        disp.vj       = rat_busy_q[rs1] ? query.value1 : rf_read(rs1);
        disp.qj       = rat_tag_q[rs1];
        disp.qj_valid = rat_busy_q[rs1] && !query.ready1;
        disp.qk       = rat_tag_q[rs2];
        if (is_imm) begin
            disp.vk       = imm;
            disp.qk_valid = 1'b0;
        end else begin
            disp.vk       = rat_busy_q[rs2] ? query.value2 : rf_read(rs2);
            disp.qk_valid = rat_busy_q[rs2] && !query.ready2;
        end
    end

    assign issue          = fq_valid_i && !rob_full_i && !disp.full;
    assign fq_pop_o       = issue;
    assign rob_alloc_we_o = issue;
    assign rob_alloc_rd_o = rd;
    assign rob_alloc_pc_o = fq_pc_i;
    assign disp.we        = issue;
    assign disp.dest      = rob_alloc_id_i;

    always_ff @(posedge clk_i) begin
        if (rf_we) begin
            regs[commit.rd] <= commit.value;
        end
        if (issue && rd != '0) begin
            rat_tag_q[rd] <= rob_alloc_id_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rat_busy_q <= '0;
        end else begin
            // A younger writer keeps the entry
            if (rf_we && rat_tag_q[commit.rd] == commit.id) begin
                rat_busy_q[commit.rd] <= 1'b0;
            end
            if (issue && rd != '0) begin
                rat_busy_q[rd] <= 1'b1;
            end
        end
    end

endmodule

/* logic/reservation_station.sv */
module reservation_station import ooo_pkg::*; #(
    parameter int  RS_DEPTH  = 4,
    parameter int  ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    dispatch_if.sink         disp,
    cdb_if.listener          cdb,
    output logic             ex_valid_o,
    output alu_op_e          ex_op_o,
    output logic [XLEN-1:0]  ex_a_o,
    output logic [XLEN-1:0]  ex_b_o,
    output logic [TAG_W-1:0] ex_dest_o
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0] busy_q;
    logic [RS_DEPTH-1:0] wait_j_q;
    logic [RS_DEPTH-1:0] wait_k_q;
    logic [RS_DEPTH-1:0] ready;
    logic [RS_DEPTH-1:0] cap_j;
    logic [RS_DEPTH-1:0] cap_k;
    alu_op_e             op_q   [RS_DEPTH];
    logic [XLEN-1:0]     vj_q   [RS_DEPTH];
    logic [XLEN-1:0]     vk_q   [RS_DEPTH];
    logic [TAG_W-1:0]    qj_q   [RS_DEPTH];
    logic [TAG_W-1:0]    qk_q   [RS_DEPTH];
    logic [TAG_W-1:0]    dest_q [RS_DEPTH];
    logic [IDX_W-1:0]    sel_idx;
    logic [IDX_W-1:0]    free_idx;

    assign ready      = busy_q & ~wait_j_q & ~wait_k_q;
    assign disp.full  = &busy_q;
    assign ex_valid_o = |ready;
    assign ex_op_o    = op_q[sel_idx];
    assign ex_a_o     = vj_q[sel_idx];
    assign ex_b_o     = vk_q[sel_idx];
    assign ex_dest_o  = dest_q[sel_idx];

    // Lowest index wins, both for issue and for allocation
    always_comb begin
        sel_idx  = '0;
        free_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel_idx = IDX_W'(i);
            end
            if (!busy_q[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    // CDB snoop
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            cap_j[i] = cdb.valid && busy_q[i] && wait_j_q[i] && (qj_q[i] == cdb.rob_id);
            cap_k[i] = cdb.valid && busy_q[i] && wait_k_q[i] && (qk_q[i] == cdb.rob_id);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q   <= '0;
            wait_j_q <= '0;
            wait_k_q <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (disp.we && free_idx == IDX_W'(i)) begin
                    busy_q[i]   <= 1'b1;
                    wait_j_q[i] <= disp.qj_valid;
                    wait_k_q[i] <= disp.qk_valid;
                end else begin
                    if (ex_valid_o && sel_idx == IDX_W'(i)) begin
                        busy_q[i] <= 1'b0;
                    end
                    if (cap_j[i]) begin
                        wait_j_q[i] <= 1'b0;
                    end
                    if (cap_k[i]) begin
                        wait_k_q[i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (disp.we && free_idx == IDX_W'(i)) begin
                op_q[i]   <= disp.op;
                vj_q[i]   <= disp.vj;
                qj_q[i]   <= disp.qj;
                vk_q[i]   <= disp.vk;
                qk_q[i]   <= disp.qk;
                dest_q[i] <= disp.dest;
            end else begin
                if (cap_j[i]) begin
                    vj_q[i] <= cdb.value;
                end
                if (cap_k[i]) begin
                    vk_q[i] <= cdb.value;
                end
            end
        end
    end

endmodule

/* logic/alu_exec.sv */
module alu_exec import ooo_pkg::*; #(
    parameter int  ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             ex_valid_i,
    input  alu_op_e          ex_op_i,
    input  logic [XLEN-1:0]  ex_a_i,
    input  logic [XLEN-1:0]  ex_b_i,
    input  logic [TAG_W-1:0] ex_dest_i,
    cdb_if.driver            cdb
);

    logic [XLEN-1:0]  result;
    logic             valid_q;
    logic [TAG_W-1:0] tag_q;
    logic [XLEN-1:0]  value_q;

    always_comb begin
        case (ex_op_i)
            ALU_ADD: result = ex_a_i + ex_b_i;
            ALU_SUB: result = ex_a_i - ex_b_i;
            ALU_AND: result = ex_a_i & ex_b_i;
            ALU_OR:  result = ex_a_i | ex_b_i;
            ALU_XOR: result = ex_a_i ^ ex_b_i;
            ALU_SLT: result = XLEN'($signed(ex_a_i) < $signed(ex_b_i));
            // Shift amount from the low five bits
            ALU_SLL: result = ex_a_i << ex_b_i[4:0];
            ALU_SRL: result = ex_a_i >> ex_b_i[4:0];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= ex_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ex_valid_i) begin
            tag_q   <= ex_dest_i;
            value_q <= result;
        end
    end

    assign cdb.valid  = valid_q;
    assign cdb.rob_id = tag_q;
    assign cdb.value  = value_q;

endmodule

/* logic/reorder_buffer.sv */
module reorder_buffer import ooo_pkg::*; #(
    parameter int  ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              alloc_we_i,
    input  logic [REG_AW-1:0] alloc_rd_i,
    input  logic [XLEN-1:0]   alloc_pc_i,
    output logic [TAG_W-1:0]  alloc_id_o,
    output logic              full_o,
    rob_query_if.responder    query,
    cdb_if.listener           cdb,
    commit_if.source          commit,
    output logic [XLEN-1:0]   commit_pc_o
);

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    logic [TAG_W-1:0]     head_q;
    logic [TAG_W-1:0]     tail_q;
    logic [CNT_W-1:0]     count_q;
    logic [ROB_DEPTH-1:0] ready_q;
    logic [REG_AW-1:0]    rd_q    [ROB_DEPTH];
    logic [XLEN-1:0]      pc_q    [ROB_DEPTH];
    logic [XLEN-1:0]      value_q [ROB_DEPTH];
    logic                 retire;

    assign alloc_id_o = tail_q;
    assign full_o     = (count_q == CNT_W'(ROB_DEPTH));

    // Head offered as soon as its result is stored
    assign retire       = (count_q != '0) && ready_q[head_q];
    assign commit.valid = retire;
    assign commit.id    = head_q;
    assign commit.rd    = rd_q[head_q];
    assign commit.value = value_q[head_q];
    assign commit_pc_o  = pc_q[head_q];

    // Same-cycle CDB result counts as ready
    assign query.ready1 = ready_q[query.id1] || (cdb.valid && cdb.rob_id == query.id1);
    assign query.value1 = ready_q[query.id1] ? value_q[query.id1] : cdb.value;
    assign query.ready2 = ready_q[query.id2] || (cdb.valid && cdb.rob_id == query.id2);
    assign query.value2 = ready_q[query.id2] ? value_q[query.id2] : cdb.value;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            ready_q <= '0;
        end else begin
            if (alloc_we_i) begin
                tail_q          <= tail_q + 1'b1;
                ready_q[tail_q] <= 1'b0;
            end
            if (cdb.valid) begin
                ready_q[cdb.rob_id] <= 1'b1;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(alloc_we_i) - CNT_W'(retire);
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_we_i) begin
            rd_q[tail_q] <= alloc_rd_i;
            pc_q[tail_q] <= alloc_pc_i;
        end
        if (cdb.valid) begin
            value_q[cdb.rob_id] <= cdb.value;
        end
    end

endmodule

/* logic/ooo_core.sv */
module ooo_core import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    parameter int RS_DEPTH  = 4,
    parameter int FQ_DEPTH  = 4
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    output logic [XLEN-1:0]   inst_addr_o,
    output logic              inst_ce_o,
    input  logic [XLEN-1:0]   inst_i,
    output logic              commit_valid_o,
    output logic [XLEN-1:0]   commit_pc_o,
    output logic [REG_AW-1:0] commit_rd_o,
    output logic [XLEN-1:0]   commit_value_o
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    dispatch_if  #(.TAG_W(TAG_W)) disp_bus ();
    cdb_if       #(.TAG_W(TAG_W)) cdb_bus ();
    rob_query_if #(.TAG_W(TAG_W)) query_bus ();
    commit_if    #(.TAG_W(TAG_W)) commit_bus ();

    // Fetch queue to rename
    logic              fq_valid;
    logic              fq_pop;
    logic [XLEN-1:0]   fq_inst;
    logic [XLEN-1:0]   fq_pc;

    // Rename to ROB allocation
    logic              rob_full;
    logic              rob_alloc_we;
    logic [TAG_W-1:0]  rob_alloc_id;
    logic [REG_AW-1:0] rob_alloc_rd;
    logic [XLEN-1:0]   rob_alloc_pc;

    // Station to ALU
    logic              ex_valid;
    alu_op_e           ex_op;
    logic [XLEN-1:0]   ex_a;
    logic [XLEN-1:0]   ex_b;
    logic [TAG_W-1:0]  ex_dest;

    fetch_queue #(.FQ_DEPTH(FQ_DEPTH)) u_fetch_queue (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .inst_i(inst_i), .inst_addr_o(inst_addr_o), .inst_ce_o(inst_ce_o),
        .fq_pop_i(fq_pop), .fq_valid_o(fq_valid), .fq_inst_o(fq_inst), .fq_pc_o(fq_pc)
    );

    rename_issue #(.ROB_DEPTH(ROB_DEPTH)) u_rename_issue (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .fq_valid_i(fq_valid), .fq_inst_i(fq_inst), .fq_pc_i(fq_pc), .fq_pop_o(fq_pop),
        .rob_full_i(rob_full), .rob_alloc_id_i(rob_alloc_id),
        .rob_alloc_we_o(rob_alloc_we), .rob_alloc_rd_o(rob_alloc_rd),
        .rob_alloc_pc_o(rob_alloc_pc),
        .query(query_bus.requester), .commit(commit_bus.receiver), .disp(disp_bus.source)
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH), .ROB_DEPTH(ROB_DEPTH)) u_rs (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .disp(disp_bus.sink), .cdb(cdb_bus.listener),
        .ex_valid_o(ex_valid), .ex_op_o(ex_op), .ex_a_o(ex_a), .ex_b_o(ex_b),
        .ex_dest_o(ex_dest)
    );

    alu_exec #(.ROB_DEPTH(ROB_DEPTH)) u_alu (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .ex_valid_i(ex_valid), .ex_op_i(ex_op), .ex_a_i(ex_a), .ex_b_i(ex_b),
        .ex_dest_i(ex_dest), .cdb(cdb_bus.driver)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .alloc_we_i(rob_alloc_we), .alloc_rd_i(rob_alloc_rd), .alloc_pc_i(rob_alloc_pc),
        .alloc_id_o(rob_alloc_id), .full_o(rob_full),
        .query(query_bus.responder), .cdb(cdb_bus.listener), .commit(commit_bus.source),
        .commit_pc_o(commit_pc_o)
    );

    assign commit_valid_o = commit_bus.valid;
    assign commit_rd_o    = commit_bus.rd;
    assign commit_value_o = commit_bus.value;

endmodule

/* test/tb_clock.sv */
module tb_clock #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Release shortly after a rising edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 arst_n_o = 1'b1;
    end

endmodule

/* test/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN = 24;
localparam logic [31:0] NOP_WORD = 32'h0000_0013;

// RV32I R format, opcode OP
function automatic logic [31:0] r_word(input logic [6:0] funct7, input logic [2:0] funct3,
                                       input int rd, input int rs1, input int rs2);
    return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], 7'b0110011};
endfunction

// RV32I I format, opcode OP-IMM
function automatic logic [31:0] i_word(input logic [2:0] funct3, input int rd,
                                       input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], funct3, rd[4:0], 7'b0010011};
endfunction

function automatic logic [31:0] program_word(input int idx);
    case (idx)
        // Short chain whose tail waits in a high station slot
        0:  return i_word(3'b000, 1, 0, 5);
        1:  return r_word(7'h00, 3'b000, 2, 1, 1);
        2:  return r_word(7'h20, 3'b000, 3, 2, 1);
        3:  return r_word(7'h00, 3'b100, 4, 3, 2);
        // Independent words pass it and fill the ROB
        4:  return i_word(3'b000, 5, 0, -3);
        5:  return i_word(3'b010, 6, 1, 7);
        6:  return i_word(3'b110, 7, 2, 112);
        7:  return i_word(3'b111, 8, 3, 60);
        8:  return i_word(3'b100, 9, 2, -1);
        9:  return r_word(7'h00, 3'b000, 0, 1, 2);
        10: return r_word(7'h00, 3'b110, 10, 0, 7);
        // Long dependent chain that keeps the station full
        11: return r_word(7'h00, 3'b000, 11, 4, 6);
        12: return r_word(7'h00, 3'b001, 12, 11, 6);
        13: return r_word(7'h00, 3'b101, 13, 12, 8);
        14: return i_word(3'b000, 11, 11, 100);
        15: return r_word(7'h00, 3'b010, 14, 5, 13);
        16: return r_word(7'h00, 3'b110, 15, 14, 11);
        17: return r_word(7'h00, 3'b111, 16, 15, 7);
        18: return r_word(7'h00, 3'b100, 17, 16, 9);
        // x1 reused and x0 as a destination
        19: return r_word(7'h20, 3'b000, 1, 17, 8);
        20: return r_word(7'h00, 3'b000, 1, 1, 1);
        21: return i_word(3'b000, 0, 1, 7);
        22: return i_word(3'b010, 18, 1, 0);
        23: return r_word(7'h20, 3'b000, 19, 18, 1);
        default: return NOP_WORD;
    endcase
endfunction

`endif

/* test/core_asserts.sv */
`include "tb_program.svh"

module core_asserts import ooo_pkg::*; (
    input logic              clk_i,
    input logic              arst_n_i,
    input logic [XLEN-1:0]   inst_addr_i,
    input logic              inst_ce_i,
    input logic              commit_valid_i,
    input logic [XLEN-1:0]   commit_pc_i,
    input logic [REG_AW-1:0] commit_rd_i,
    input logic [XLEN-1:0]   commit_value_i
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int STALL_LIMIT = 40;
    localparam logic [XLEN-1:0] LAST_PC = XLEN'((PROG_LEN - 1) * 4);

    logic [XLEN-1:0]   shadow [32];
    logic [XLEN-1:0]   word;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic [REG_AW-1:0] exp_rd;
    logic [XLEN-1:0]   exp_value;
    logic [XLEN-1:0]   exp_pc_q;
    logic [XLEN-1:0]   exp_addr_q;
    int                idle_q;
    logic              done_q;
    logic              fail_value = 1'b0;
    logic              fail_rd = 1'b0;
    logic              fail_pc = 1'b0;
    logic              fail_reset = 1'b0;
    logic              fail_progress = 1'b0;
    logic              fail_addr = 1'b0;
    logic              failed;

    assign failed = fail_value | fail_rd | fail_pc | fail_reset | fail_progress | fail_addr;

    // Reference execution of the word being retired
    always_comb begin
        word   = program_word(int'(commit_pc_i[XLEN-1:2]));
        exp_rd = word[11:7];
        imm    = {{20{word[31]}}, word[31:20]};
        op_a   = shadow[word[19:15]];
        op_b   = (word[6:0] == 7'b0010011) ? imm : shadow[word[24:20]];
        case (word[14:12])
            3'b000:  exp_value = (word[6:0] == 7'b0110011 && word[30]) ? op_a - op_b
                                                                       : op_a + op_b;
            3'b001:  exp_value = op_a << op_b[4:0];
            3'b010:  exp_value = {31'd0, $signed(op_a) < $signed(op_b)};
            3'b100:  exp_value = op_a ^ op_b;
            3'b101:  exp_value = op_a >> op_b[4:0];
            3'b110:  exp_value = op_a | op_b;
            default: exp_value = op_a & op_b;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
            exp_pc_q   <= '0;
            exp_addr_q <= '0;
            idle_q     <= 0;
            done_q     <= 1'b0;
        end else begin
            if (commit_valid_i) begin
                exp_pc_q <= exp_pc_q + 32'd4;
                idle_q   <= 0;
                // x0 stays zero
                if (exp_rd != 5'd0) begin
                    shadow[exp_rd] <= exp_value;
                end
                if (exp_pc_q == LAST_PC) begin
                    done_q <= 1'b1;
                end
            end else if (idle_q < 1000) begin
                idle_q <= idle_q + 1;
            end
            if (inst_ce_i) begin
                exp_addr_q <= exp_addr_q + 32'd4;
            end
        end
    end

    value_check: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        commit_valid_i |-> (commit_value_i == exp_value))
    else begin
        $error("CHECK FAILED at %0t ns: commit_value_o expected %h, actual %h",
               $time, $sampled(exp_value), $sampled(commit_value_i));
        fail_value = 1'b1;
    end

    rd_check: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        commit_valid_i |-> (commit_rd_i == exp_rd))
    else begin
        $error("CHECK FAILED at %0t ns: commit_rd_o expected %0d, actual %0d",
               $time, $sampled(exp_rd), $sampled(commit_rd_i));
        fail_rd = 1'b1;
    end

    pc_order_check: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        commit_valid_i |-> (commit_pc_i == exp_pc_q))
    else begin
        $error("CHECK FAILED at %0t ns: commit_pc_o expected %h, actual %h",
               $time, $sampled(exp_pc_q), $sampled(commit_pc_i));
        fail_pc = 1'b1;
    end

    reset_quiet_check: assert property (@(posedge clk_i)
        (!arst_n_i || $rose(arst_n_i)) |-> (!commit_valid_i && !inst_ce_i))
    else begin
        $error("CHECK FAILED at %0t ns: commit_valid_o/inst_ce_o expected 0/0, actual %b/%b",
               $time, $sampled(commit_valid_i), $sampled(inst_ce_i));
        fail_reset = 1'b1;
    end

    progress_check: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !done_q |-> (idle_q < STALL_LIMIT))
    else begin
        $error("CHECK FAILED at %0t ns: no instruction retired for %0d cycles, next pc %h",
               $time, $sampled(idle_q), $sampled(exp_pc_q));
        fail_progress = 1'b1;
    end

    fetch_addr_check: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        inst_ce_i |-> (inst_addr_i == exp_addr_q))
    else begin
        $error("CHECK FAILED at %0t ns: inst_addr_o expected %h, actual %h",
               $time, $sampled(exp_addr_q), $sampled(inst_addr_i));
        fail_addr = 1'b1;
    end

endmodule

/* test/tb_top.sv */
`include "tb_program.svh"

module tb_top import ooo_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_TIMEOUT = 20;
    localparam int RUN_TIMEOUT   = 2000;
    localparam int DRIVE_DELAY   = 1;
    localparam logic [XLEN-1:0] LAST_PC = XLEN'((PROG_LEN - 1) * 4);

    logic              clk;
    logic              arst_n;
    logic [XLEN-1:0]   inst_addr;
    logic              inst_ce;
    logic [XLEN-1:0]   inst_word = NOP_WORD;
    logic              commit_valid;
    logic [XLEN-1:0]   commit_pc;
    logic [REG_AW-1:0] commit_rd;
    logic [XLEN-1:0]   commit_value;
    logic [XLEN-1:0]   mem_addr;
    logic              finished;
    logic              assert_failed;

    tb_clock #(.HALF_PERIOD(4), .RESET_CYCLES(3)) clock_gen (
        .clk_o(clk),
        .arst_n_o(arst_n)
    );

    ooo_core #(.ROB_DEPTH(8), .RS_DEPTH(4), .FQ_DEPTH(4)) ooo_core_inst (
        .clk_i(clk),
        .arst_n_i(arst_n),
        .inst_addr_o(inst_addr),
        .inst_ce_o(inst_ce),
        .inst_i(inst_word),
        .commit_valid_o(commit_valid),
        .commit_pc_o(commit_pc),
        .commit_rd_o(commit_rd),
        .commit_value_o(commit_value)
    );

    bind ooo_core core_asserts core_asserts_inst (
        .clk_i(clk_i),
        .arst_n_i(arst_n_i),
        .inst_addr_i(inst_addr_o),
        .inst_ce_i(inst_ce_o),
        .commit_valid_i(commit_valid_o),
        .commit_pc_i(commit_pc_o),
        .commit_rd_i(commit_rd_o),
        .commit_value_i(commit_value_o)
    );

    assign assert_failed = ooo_core_inst.core_asserts_inst.failed;

    // Instruction memory, word valid for the whole cycle after the enabled edge
    always @(posedge clk) begin
        if (inst_ce) begin
            mem_addr = inst_addr;
            #(DRIVE_DELAY) inst_word = program_word(int'(mem_addr[XLEN-1:2]));
        end
    end

    initial begin : run_control
        int cycles;
        finished = 1'b0;
        cycles   = 0;
        while (!arst_n && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        cycles = 0;
        while (arst_n && !finished && !assert_failed && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (commit_valid && commit_pc == LAST_PC) begin
                finished = 1'b1;
            end
        end
        // Let the checker see the last retirement
        repeat (2) @(posedge clk);
        if (assert_failed || !finished) begin
            $display("TESTBENCH FAILED");
            if (assert_failed) begin
                $display("A checker assertion failed, see the CHECK FAILED line above");
            end else if (!arst_n) begin
                $display("Reset was never released within %0d cycles", RESET_TIMEOUT);
            end else begin
                $display("Timeout after %0d cycles: the instruction at pc %h never retired",
                         RUN_TIMEOUT, LAST_PC);
                $display("Retirement stalled with commit_valid_o=%b at pc %h",
                         commit_valid, commit_pc);
            end
            $fatal(1, "Simulation stopped on failure");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* project.f */
+incdir+test
logic/ooo_pkg.sv
logic/core_if.sv
logic/fetch_queue.sv
logic/rename_issue.sv
logic/reservation_station.sv
logic/alu_exec.sv
logic/reorder_buffer.sv
logic/ooo_core.sv
test/tb_clock.sv
test/core_asserts.sv
test/tb_top.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module tb_top \
    -f project.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
printf '%s\n' "$output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

if printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
